// ==== aes_lite.f ====
hdl/aes_lite_pkg.sv
hdl/aes_round_ctrl_if.sv
hdl/aes_cipher_control.sv
hdl/aes_state_datapath.sv
hdl/aes_key_expand.sv
hdl/aes_lite_core.sv
sim/aes_lite_clk_gen.sv
sim/aes_lite_properties.sv
sim/aes_lite_tb.sv

// ==== hdl/aes_cipher_control.sv ====
// One block in flight. in_ready_o stays low from acceptance until the output handshake.
`timescale 1ns/1ps

module aes_cipher_control
  import aes_lite_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,

  // Input handshake
  input  logic        in_valid_i,
  output logic        in_ready_o,

  // Output handshake
  output logic        out_valid_o,
  input  logic        out_ready_i,

  aes_round_ctrl_if.ctrl ctrl_if
);

  logic [1:0]            fsm_q, fsm_d;
  logic [RndCtrBits-1:0] rnd_ctr_q, rnd_ctr_d;
  logic                  last_round;

  assign last_round = (rnd_ctr_q == NumRounds);
  assign ctrl_if.rnd_ctr = rnd_ctr_q;

  //////////////////////////////////////////////////
  // Next state and control outputs
  //////////////////////////////////////////////////

  always_comb begin : fsm_comb
    fsm_d     = fsm_q;
    rnd_ctr_d = rnd_ctr_q;

    in_ready_o  = 1'b0;
    out_valid_o = 1'b0;

    ctrl_if.state_sel = StateRound;
    ctrl_if.state_we  = 1'b0;
    ctrl_if.key_we    = 1'b0;
    ctrl_if.key_load  = 1'b0;

    case (fsm_q)
      CtrlIdle: begin
        in_ready_o        = 1'b1;
        ctrl_if.state_sel = StateLoad;                 // Data XOR key.
        ctrl_if.key_load  = 1'b1;
        if (in_valid_i) begin
          ctrl_if.state_we = 1'b1;
          ctrl_if.key_we   = 1'b1;
          rnd_ctr_d        = 4'd1;
          fsm_d            = CtrlRound;
        end
      end

      CtrlRound: begin
        ctrl_if.state_we = 1'b1;                       // One round per cycle.
        ctrl_if.key_we   = 1'b1;
        if (last_round) begin
          ctrl_if.state_sel = StateFinal;
          rnd_ctr_d         = '0;
          fsm_d             = CtrlDone;
        end else begin
          rnd_ctr_d = rnd_ctr_q + 4'd1;
        end
      end

      CtrlDone: begin
        // Hold the result until it is taken.
        out_valid_o = 1'b1;
        if (out_ready_i) begin
          fsm_d = CtrlIdle;
        end
      end

      default: begin
        fsm_d     = CtrlIdle;                          // Unused encoding.
        rnd_ctr_d = '0;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin : fsm_reg
    if (reset_i) begin
      fsm_q     <= CtrlIdle;
      rnd_ctr_q <= '0;
    end else begin
      fsm_q     <= fsm_d;
      rnd_ctr_q <= rnd_ctr_d;
    end
  end

endmodule

// ==== hdl/aes_key_expand.sv ====
// AES-128 schedule only. The key register has no reset and is loaded with each new block.
`timescale 1ns/1ps

module aes_key_expand
  import aes_lite_pkg::*;
(
  input  logic                 clk_i,
  input  logic [BlockBits-1:0] key_i,
  aes_round_ctrl_if.key        ctrl_if,
  output logic [BlockBits-1:0] round_key_o
);

  aes_state_u  key_q;                                  // Key of the previous round.
  aes_state_u  key_nxt;
  logic [31:0] rot_word;
  logic [31:0] temp;

  // Word w3 of the current key sits in cols[0].
  assign rot_word = {key_q.cols[0][23:0], key_q.cols[0][31:24]};

  always_comb begin : expand_comb
    for (int i = 0; i < 4; i++) begin
      temp[8*i +: 8] = aes_sbox(rot_word[8*i +: 8]);  // SubWord.
    end
    temp[31:24] = temp[31:24] ^ aes_rcon(ctrl_if.rnd_ctr);

    key_nxt.cols[3] = key_q.cols[3] ^ temp;
    key_nxt.cols[2] = key_q.cols[2] ^ key_nxt.cols[3];
    key_nxt.cols[1] = key_q.cols[1] ^ key_nxt.cols[2];
    key_nxt.cols[0] = key_q.cols[0] ^ key_nxt.cols[1];
  end

  // At load the cipher key itself is round key 0.
  assign round_key_o = ctrl_if.key_load ? key_i : key_nxt;

  always_ff @(posedge clk_i) begin : key_reg
    if (ctrl_if.key_we) begin
      key_q <= round_key_o;
    end
  end

endmodule

// ==== hdl/aes_lite_core.sv ====
// AES-128 encryption with 10 cycles from input acceptance to out_valid_o. One block at a time.
`timescale 1ns/1ps

module aes_lite_core
  import aes_lite_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,

  // Input side
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic [BlockBits-1:0] in_data_i,
  input  logic [BlockBits-1:0] in_key_i,

  // Output side
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [BlockBits-1:0] out_data_o
);

  logic [BlockBits-1:0] round_key;
  aes_state_u           state_q;

  aes_round_ctrl_if ctrl_if ();

  //////////////////////////////////////////////////
  // Control and datapaths
  //////////////////////////////////////////////////

  aes_cipher_control u_control (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .ctrl_if     ( ctrl_if     )
  );

  aes_state_datapath u_state (
    .clk_i       ( clk_i       ),
    .in_data_i   ( in_data_i   ),
    .round_key_i ( round_key   ),
    .ctrl_if     ( ctrl_if     ),
    .state_o     ( state_q     )
  );

  aes_key_expand u_key (
    .clk_i       ( clk_i       ),
    .key_i       ( in_key_i    ),
    .ctrl_if     ( ctrl_if     ),
    .round_key_o ( round_key   )
  );

  assign out_data_o = state_q;                         // Stable while out_valid_o waits.

endmodule

// ==== hdl/aes_lite_pkg.sv ====
// AES-128 encryption only. The S-box is a plain table and rounds are counted from 1 to 10.
package aes_lite_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  localparam int BlockBits  = 128;                     // Block and key width.
  localparam int RndCtrBits = 4;
  localparam logic [RndCtrBits-1:0] NumRounds = 4'd10;

  // Controller states.
  localparam logic [1:0] CtrlIdle  = 2'd0;
  localparam logic [1:0] CtrlRound = 2'd1;
  localparam logic [1:0] CtrlDone  = 2'd2;

  // Byte 0 of the AES state sits in bits 127:120, column 0 in bits 127:96.
  typedef union packed {
    logic [15:0][7:0] bytes;                           // SubBytes and ShiftRows view.
    logic [3:0][31:0] cols;                            // MixColumns and AddRoundKey view.
  } aes_state_u;

  typedef enum logic [1:0] {
    StateLoad  = 2'd0,                                 // Input XOR key.
    StateRound = 2'd1,
    StateFinal = 2'd2                                  // No MixColumns.
  } state_sel_e;

  //////////////////////////////////////////////////
  // S-box and round constants
  //////////////////////////////////////////////////

  // Entry 0 is the leftmost byte.
  localparam logic [0:255][7:0] sbox_lut = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  function automatic logic [7:0] aes_sbox(logic [7:0] b);
    return sbox_lut[b];
  endfunction

  // Round constant for round 1 to 10. Doubling in GF(2^8) wraps to 1b after 80.
  function automatic logic [7:0] aes_rcon(logic [RndCtrBits-1:0] rnd);
    logic [7:0] rc;
    case (rnd)
      4'd1:    rc = 8'h01;
      4'd2:    rc = 8'h02;
      4'd3:    rc = 8'h04;
      4'd4:    rc = 8'h08;
      4'd5:    rc = 8'h10;
      4'd6:    rc = 8'h20;
      4'd7:    rc = 8'h40;
      4'd8:    rc = 8'h80;
      4'd9:    rc = 8'h1b;
      4'd10:   rc = 8'h36;
      default: rc = 8'h00;                             // Outside the rounds.
    endcase
    return rc;
  endfunction

endpackage

// ==== hdl/aes_round_ctrl_if.sv ====
// Round control from the FSM to both datapaths. Nothing flows back since latency is fixed.
`timescale 1ns/1ps

interface aes_round_ctrl_if
  import aes_lite_pkg::*;
();

  state_sel_e            state_sel;                    // Next value of the state register.
  logic                  state_we;
  logic                  key_we;
  logic                  key_load;                     // Take the external key.
  logic [RndCtrBits-1:0] rnd_ctr;                      // Round being computed.

  modport ctrl (
    output state_sel, state_we, key_we, key_load, rnd_ctr
  );

  modport state (
    input state_sel, state_we
  );

  modport key (
    input key_we, key_load, rnd_ctr
  );

endinterface

// ==== hdl/aes_state_datapath.sv ====
// The state register has no reset. Its contents are only valid once a block has been loaded.
`timescale 1ns/1ps

module aes_state_datapath
  import aes_lite_pkg::*;
(
  input  logic                 clk_i,
  input  logic [BlockBits-1:0] in_data_i,
  input  logic [BlockBits-1:0] round_key_i,            // Key for the round being computed.
  aes_round_ctrl_if.state      ctrl_if,
  output aes_state_u           state_o
);

  aes_state_u state_q, state_d;
  aes_state_u rk;
  aes_state_u sub, shift, mix;
  aes_state_u full_rk, final_rk;

  assign rk = round_key_i;

  // Multiply by x in GF(2^8).
  function automatic logic [7:0] xtime(logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic logic [31:0] mix_col(logic [31:0] w);
    logic [7:0] a0, a1, a2, a3;
    a0 = w[31:24];
    a1 = w[23:16];
    a2 = w[15:8];
    a3 = w[7:0];
    return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
  endfunction

  //////////////////////////////////////////////////
  // Round function
  //////////////////////////////////////////////////

  always_comb begin : round_comb
    for (int i = 0; i < 16; i++) begin
      sub.bytes[i] = aes_sbox(state_q.bytes[i]);
    end
    // Row r rotates left by r columns.
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shift.bytes[15-4*c-r] = sub.bytes[15-4*((c+r)%4)-r];
      end
    end
    for (int c = 0; c < 4; c++) begin
      mix.cols[c]      = mix_col(shift.cols[c]);
      full_rk.cols[c]  = mix.cols[c] ^ rk.cols[c];   // AddRoundKey.
      final_rk.cols[c] = shift.cols[c] ^ rk.cols[c];
    end
  end

  always_comb begin : next_sel
    case (ctrl_if.state_sel)
      StateLoad:  state_d = in_data_i ^ round_key_i;
      StateFinal: state_d = final_rk;
      default:    state_d = full_rk;
    endcase
  end

  always_ff @(posedge clk_i) begin : state_reg
    if (ctrl_if.state_we) begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;                            // Ciphertext after the last round.

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module aes_lite_tb -f aes_lite.f -o aes_lite_sim \
  && { ./obj_dir/aes_lite_sim +verilator+error+limit+100 > sim.log 2>&1 || true; } \
  && grep -q "^TEST PASSED$" sim.log \
  && echo "Simulation passed, see sim.log" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== sim/aes_lite_clk_gen.sv ====
// Free-running 20 ns clock. Reset is held high over the first 5 rising edges.
`timescale 1ns/1ps

module aes_lite_clk_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin : clk_drive
    clk_o = 1'b0;
    forever begin
      #10 clk_o = ~clk_o;
    end
  end

  initial begin : reset_drive
    reset_o = 1'b1;
    repeat (5) @(posedge clk_o);
    #2;
    reset_o = 1'b0;                                    // Released at the drive point.
  end

endmodule

// ==== sim/aes_lite_properties.sv ====
// Top-level handshake, latency and hold rules of the core. Needs assertions enabled at build.
`timescale 1ns/1ps

module aes_lite_properties
  import aes_lite_pkg::*;
(
  input logic                 clk_i,
  input logic                 reset_i,
  input logic                 in_valid_i,
  input logic                 in_ready_i,
  input logic                 out_valid_i,
  input logic                 out_ready_i,
  input logic [BlockBits-1:0] out_data_i
);

  int unsigned fail_count = 0;                         // Polled by the testbench.

  logic accept;
  logic deliver;

  assign accept  = in_valid_i && in_ready_i;
  assign deliver = out_valid_i && out_ready_i;

  //////////////////////////////////////////////////
  // Reset and latency
  //////////////////////////////////////////////////

  a_reset_state: assert property (@(posedge clk_i)
    $fell(reset_i) |-> in_ready_i && !out_valid_i)
    else begin
      fail_count++;
      $error("in_ready_o or out_valid_o wrong on the first cycle after reset");
    end

  // Result shows up in the cycle after the tenth round edge.
  a_latency_min: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(out_valid_i) |-> $past(accept, 11))
    else begin
      fail_count++;
      $error("out_valid_o rose without an acceptance 10 cycles before");
    end

  a_latency_max: assert property (@(posedge clk_i) disable iff (reset_i)
    $past(accept, 11) |-> $rose(out_valid_i))
    else begin
      fail_count++;
      $error("out_valid_o did not rise 10 cycles after acceptance");
    end

  //////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////

  a_out_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i))
    else begin
      fail_count++;
      $error("out_valid_o or out_data_o changed under back-pressure");
    end

  a_no_overlap: assert property (@(posedge clk_i) disable iff (reset_i)
    !(in_ready_i && out_valid_i))
    else begin
      fail_count++;
      $error("in_ready_o high while out_valid_o is high");
    end

  a_busy_after_accept: assert property (@(posedge clk_i) disable iff (reset_i)
    accept |=> !in_ready_i)
    else begin
      fail_count++;
      $error("in_ready_o still high after acceptance");
    end

  a_busy_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    !in_ready_i && !deliver |=> !in_ready_i)
    else begin
      fail_count++;
      $error("in_ready_o rose before the output handshake");
    end

  a_ready_after_out: assert property (@(posedge clk_i) disable iff (reset_i)
    deliver |=> in_ready_i)
    else begin
      fail_count++;
      $error("in_ready_o not high after the output handshake");
    end

endmodule

// ==== sim/aes_lite_tb.sv ====
// Runs FIPS-197 vectors only. Relies on the bound properties and on assertions being enabled.
`timescale 1ns/1ps

module aes_lite_tb
  import aes_lite_pkg::*;
();

  localparam int TimeoutCycles = 400;                  // Four blocks with stalls, plus margin.
  localparam int NumBlocks     = 4;

  logic                 clk_i;
  logic                 reset_i;
  logic                 in_valid_i;
  logic                 in_ready_o;
  logic [BlockBits-1:0] in_data_i;
  logic [BlockBits-1:0] in_key_i;
  logic                 out_valid_o;
  logic                 out_ready_i;
  logic [BlockBits-1:0] out_data_o;

  // Appendix C.1, B, B again and C.1 again.
  logic [BlockBits-1:0] plain_vec [NumBlocks] = '{
    128'h00112233445566778899aabbccddeeff, 128'h3243f6a8885a308d313198a2e0370734,
    128'h3243f6a8885a308d313198a2e0370734, 128'h00112233445566778899aabbccddeeff};
  logic [BlockBits-1:0] key_vec [NumBlocks] = '{
    128'h000102030405060708090a0b0c0d0e0f, 128'h2b7e151628aed2a6abf7158809cf4f3c,
    128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h000102030405060708090a0b0c0d0e0f};
  logic [BlockBits-1:0] cipher_vec [NumBlocks] = '{
    128'h69c4e0d86a7b0430d8cdb78070b4c55a, 128'h3925841d02dc09fbdc118597196a0b32,
    128'h3925841d02dc09fbdc118597196a0b32, 128'h69c4e0d86a7b0430d8cdb78070b4c55a};

  integer               seed = 77;
  int unsigned          cycle_count = 0;
  logic [BlockBits-1:0] exp_q [$];                     // Ciphertexts of accepted blocks.

  aes_lite_clk_gen u_clk_gen (
    .clk_o   ( clk_i   ),
    .reset_o ( reset_i )
  );

  aes_lite_core dut (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .in_data_i   ( in_data_i   ),
    .in_key_i    ( in_key_i    ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .out_data_o  ( out_data_o  )
  );

  bind aes_lite_core aes_lite_properties u_props (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_i  ( in_ready_o  ),
    .out_valid_i ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .out_data_i  ( out_data_o  )
  );

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  //////////////////////////////////////////////////
  // Producer and consumer
  //////////////////////////////////////////////////

  // Next block stays valid while the previous one is still in flight.
  task automatic send_blocks();
    logic accepted;
    for (int i = 0; i < NumBlocks; i++) begin
      in_valid_i = 1'b1;
      in_data_i  = plain_vec[i];
      in_key_i   = key_vec[i];
      accepted   = 1'b0;
      while (!accepted) begin
        @(negedge clk_i);
        accepted = in_valid_i && in_ready_o;
        if (accepted) begin
          exp_q.push_back(cipher_vec[i]);
        end
        @(posedge clk_i);
        #2;
      end
    end
    in_valid_i = 1'b0;
  endtask

  task automatic receive_blocks();
    int unsigned          stall;
    logic [BlockBits-1:0] expected;
    for (int n = 0; n < NumBlocks; n++) begin
      @(negedge clk_i);
      while (!out_valid_o) begin
        @(negedge clk_i);
      end
      stall = 1 + ({$random(seed)} % 40);              // Always some back-pressure.
      repeat (stall) @(posedge clk_i);
      #2;
      out_ready_i = 1'b1;
      @(negedge clk_i);
      if (exp_q.size() == 0) begin
        $display("Error: an output block arrived with no accepted block waiting for it");
        abort_run();
      end else begin
        expected = exp_q.pop_front();
        assert (out_data_o == expected) else begin
          $display("Error at time %0t: out_data_o expected %h, actual %h",
                   $time, expected, out_data_o);
          abort_run();
        end
        @(posedge clk_i);
        #2;
        out_ready_i = 1'b0;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////

  always @(negedge clk_i) begin : watchdog
    cycle_count = cycle_count + 1;
    if (dut.u_props.fail_count != 0) begin
      $display("Error: a concurrent assertion on the DUT failed at time %0t", $time);
      abort_run();
    end else if (cycle_count >= TimeoutCycles) begin
      $display("Error: timeout, the blocks did not complete within %0d cycles", TimeoutCycles);
      abort_run();
    end
  end

  initial begin : main
    in_valid_i  = 1'b0;
    in_data_i   = '0;
    in_key_i    = '0;
    out_ready_i = 1'b0;
    @(negedge reset_i);
    @(posedge clk_i);
    #2;
    fork
      send_blocks();
      receive_blocks();
    join
    repeat (3) @(negedge clk_i);                       // Let the last properties settle.
    if (dut.u_props.fail_count != 0) begin
      $display("Error: a concurrent assertion on the DUT failed before the end of the run");
      abort_run();
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule
